// ==== verilog/servoRegPkg.sv ====
// shared widths, register map and servo timing; pulseWidthFor assumes PULSE_BASE + 7*PULSE_STEP fits in 32 bits
package servoRegPkg;

	// bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 5;
	localparam int ADC_W = 8;
	localparam int CASE_W = 3;
	localparam int DISPLAY_W = 16;

	localparam int REG_COUNT = 1 << ADDR_W;

	// lowest register bit shown on the display
	localparam int DISPLAY_LSB = 5;

	typedef logic [DATA_W-1:0] dataT;
	typedef logic [ADDR_W-1:0] regAddrT;
	typedef logic [ADC_W-1:0] adcSampleT;
	typedef logic [CASE_W-1:0] servoCaseT;
	typedef logic [DISPLAY_W-1:0] displayT;

	// mapped entries
	localparam regAddrT REG_ZERO = 5'd0;
	localparam regAddrT REG_ADC = 5'd1;
	localparam regAddrT REG_SERVO = 5'd2;
	localparam regAddrT REG_DISPLAY = 5'd3;
	localparam regAddrT REG_REST = 5'd5;
	localparam regAddrT REG_ACTIVE = 5'd6;
	localparam regAddrT REG_ADC_READY = 5'd8;

	// high time of the servo pulse in clock cycles for one position case
	function automatic int unsigned pulseWidthFor(
		servoCaseT caseIn,
		int unsigned pulseBase,
		int unsigned pulseStep
	);
		int unsigned steps;
		steps = int'(caseIn);
		return pulseBase + steps * pulseStep;
	endfunction

	// case 7 gives the longest pulse
	function automatic int unsigned maxPulseWidth(
		int unsigned pulseBase,
		int unsigned pulseStep
	);
		servoCaseT topCase;
		topCase = '1;
		return pulseWidthFor(topCase, pulseBase, pulseStep);
	endfunction

endpackage

// ==== verilog/ioRegFile.sv ====
// entries 0, 1, 5, 6 and 8 ignore writes and clearRegs; rest, active and adcSample must already be synchronous to clock
`timescale 1ns/1ps

module ioRegFile (
	input logic clock,
	input logic rstN,
	input logic writeEnable,
	input logic clearRegs,
	input servoRegPkg::regAddrT writeAddr,
	input servoRegPkg::regAddrT readAddrA,
	input servoRegPkg::regAddrT readAddrB,
	input servoRegPkg::dataT writeData,
	input servoRegPkg::adcSampleT adcSample,
	input logic rest,
	input logic active,
	input logic adcReady,
	output servoRegPkg::dataT readDataA,
	output servoRegPkg::dataT readDataB,
	output servoRegPkg::servoCaseT servoCase,
	output servoRegPkg::displayT displayWord
);

	import servoRegPkg::*;

	dataT entries [0:REG_COUNT-1];

	// indexes that the processor cannot write
	function automatic logic isReadOnly(regAddrT idx);
		logic readOnly;
		readOnly = idx inside {REG_ZERO, REG_ADC, REG_REST, REG_ACTIVE, REG_ADC_READY};
		return readOnly;
	endfunction

	// value loaded into a read-only entry at the next edge
	function automatic dataT sampledFor(
		regAddrT idx,
		adcSampleT adcIn,
		logic restIn,
		logic activeIn,
		logic readyIn
	);
		dataT value;
		value = '0;
		case (idx)
			REG_ADC: begin
				value = {{(DATA_W-ADC_W){1'b0}}, adcIn};
			end
			REG_REST: begin
				value = {{(DATA_W-1){1'b0}}, restIn};
			end
			REG_ACTIVE: begin
				value = {{(DATA_W-1){1'b0}}, activeIn};
			end
			REG_ADC_READY: begin
				value = {{(DATA_W-1){1'b0}}, readyIn};
			end
			default: begin
				value = '0;
			end
		endcase
		return value;
	endfunction

	// storage and write decode
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				entries[i] <= '0;
			end
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				if (isReadOnly(regAddrT'(i))) begin
					// I/O entries reload every cycle, entry 0 stays zero
					entries[i] <= sampledFor(regAddrT'(i), adcSample, rest, active, adcReady);
				end else if (clearRegs) begin
					entries[i] <= '0;
				end else if (writeEnable && (writeAddr == regAddrT'(i))) begin
					entries[i] <= writeData;
				end
			end
		end
	end

	// read ports see the value before this edge's write
	assign readDataA = entries[readAddrA];
	assign readDataB = entries[readAddrB];

	// outputs to the servo and display
	assign servoCase = entries[REG_SERVO][CASE_W-1:0];
	assign displayWord = entries[REG_DISPLAY][DISPLAY_LSB+DISPLAY_W-1:DISPLAY_LSB];

	// entry 0 reads zero on both ports
	zeroReadA: assert property (
		@(posedge clock) disable iff (!rstN)
		(readAddrA == REG_ZERO) |-> (readDataA == '0)
	);

	zeroReadB: assert property (
		@(posedge clock) disable iff (!rstN)
		(readAddrB == REG_ZERO) |-> (readDataB == '0)
	);

	// a read-only entry never picks up the upper bits of a write
	readOnlyWrite: assert property (
		@(posedge clock) disable iff (!rstN)
		(writeEnable && isReadOnly(writeAddr))
			|=> ((entries[$past(writeAddr)] >> ADC_W) == '0)
	);

endmodule

// ==== verilog/servoPwm.sv ====
// PERIOD_CYCLES must be at least 2; a new servoCase is only picked up at the start of a frame
`timescale 1ns/1ps

module servoPwm #(
	parameter int unsigned PERIOD_CYCLES = 500000,
	parameter int unsigned PULSE_BASE = 25000,
	parameter int unsigned PULSE_STEP = 6250
) (
	input logic clock,
	input logic rstN,
	input servoRegPkg::servoCaseT servoCase,
	output logic servoOut
);

	import servoRegPkg::*;

	localparam int COUNT_W = $clog2(PERIOD_CYCLES);
	localparam int unsigned MAX_WIDTH = maxPulseWidth(PULSE_BASE, PULSE_STEP);

	typedef logic [COUNT_W-1:0] countT;

	localparam countT LAST_COUNT = countT'(PERIOD_CYCLES - 1);

	// position of the next edge inside the frame
	countT frameCount;
	logic frameStart;

	servoCaseT latchedCase;
	servoCaseT activeCase;
	countT pulseWidth;

	assign frameStart = (frameCount == '0);

	// the first cycle of a frame uses the live case
	assign activeCase = frameStart ? servoCase : latchedCase;

	// fits in COUNT_W because MAX_WIDTH is below PERIOD_CYCLES
	assign pulseWidth = countT'(pulseWidthFor(activeCase, PULSE_BASE, PULSE_STEP));

	// frame counter
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			frameCount <= '0;
		end else if (frameCount == LAST_COUNT) begin
			frameCount <= '0;
		end else begin
			frameCount <= frameCount + countT'(1);
		end
	end

	// hold the case for the whole frame
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			latchedCase <= '0;
		end else if (frameStart) begin
			latchedCase <= servoCase;
		end
	end

	// high for pulseWidth cycles from the frame start
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			servoOut <= 1'b0;
		end else begin
			servoOut <= (frameCount < pulseWidth);
		end
	end

	// longest pulse must leave a low gap before the next frame
	pulseFitsFrame: assert property (
		@(posedge clock) disable iff (!rstN)
		MAX_WIDTH < PERIOD_CYCLES
	);

endmodule

// ==== verilog/sampleTick.sv ====
// TICK_DIVIDE must be at least 2 so that adcReady drops between pulses
`timescale 1ns/1ps

module sampleTick #(
	parameter int unsigned TICK_DIVIDE = 500
) (
	input logic clock,
	input logic rstN,
	output logic adcReady
);

	localparam int COUNT_W = $clog2(TICK_DIVIDE);

	typedef logic [COUNT_W-1:0] tickCountT;

	localparam tickCountT LAST_COUNT = tickCountT'(TICK_DIVIDE - 1);

	tickCountT tickCount;

	// wraps every TICK_DIVIDE cycles and pulses on the wrap
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			tickCount <= '0;
			adcReady <= 1'b0;
		end else if (tickCount == LAST_COUNT) begin
			tickCount <= '0;
			adcReady <= 1'b1;
		end else begin
			tickCount <= tickCount + tickCountT'(1);
			adcReady <= 1'b0;
		end
	end

	// one-cycle pulse only
	singlePulse: assert property (
		@(posedge clock) disable iff (!rstN)
		adcReady |=> !adcReady
	);

endmodule

// ==== verilog/servoRegSystem.sv ====
// default timing assumes a 50 MHz clock; ADC and button inputs are taken as already synchronized
`timescale 1ns/1ps

module servoRegSystem #(
	parameter int unsigned PERIOD_CYCLES = 500000,
	parameter int unsigned PULSE_BASE = 25000,
	parameter int unsigned PULSE_STEP = 6250,
	parameter int unsigned TICK_DIVIDE = 500
) (
	input logic clock,
	input logic rstN,
	input logic writeEnable,
	input logic clearRegs,
	input servoRegPkg::regAddrT writeAddr,
	input servoRegPkg::regAddrT readAddrA,
	input servoRegPkg::regAddrT readAddrB,
	input servoRegPkg::dataT writeData,
	input servoRegPkg::adcSampleT adcSample,
	input logic rest,
	input logic active,
	output servoRegPkg::dataT readDataA,
	output servoRegPkg::dataT readDataB,
	output logic servoOut,
	output servoRegPkg::displayT displayWord
);

	import servoRegPkg::*;

	logic adcReady;
	servoCaseT servoCase;

	ioRegFile ioRegFile_inst (
		.clock(clock),
		.rstN(rstN),
		.writeEnable(writeEnable),
		.clearRegs(clearRegs),
		.writeAddr(writeAddr),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeData(writeData),
		.adcSample(adcSample),
		.rest(rest),
		.active(active),
		.adcReady(adcReady),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.servoCase(servoCase),
		.displayWord(displayWord)
	);

	// servo frame from entry 2
	servoPwm #(
		.PERIOD_CYCLES(PERIOD_CYCLES),
		.PULSE_BASE(PULSE_BASE),
		.PULSE_STEP(PULSE_STEP)
	) servoPwm_inst (
		.clock(clock),
		.rstN(rstN),
		.servoCase(servoCase),
		.servoOut(servoOut)
	);

	// stands in for the ADC conversion-done strobe
	sampleTick #(
		.TICK_DIVIDE(TICK_DIVIDE)
	) sampleTick_inst (
		.clock(clock),
		.rstN(rstN),
		.adcReady(adcReady)
	);

endmodule

// ==== tests/tbModel.svh ====
// included inside servoRegSystemTb; entry 8 mirrors the adcReady value handed in each cycle
dataT model [0:REG_COUNT-1];
int errorCount = 0;

// entries that reload from inputs and ignore writes and clears
function automatic logic isSampledEntry(int idx);
	logic sampled;
	sampled = (idx == int'(REG_ZERO)) || (idx == int'(REG_ADC)) || (idx == int'(REG_REST))
		|| (idx == int'(REG_ACTIVE)) || (idx == int'(REG_ADC_READY));
	return sampled;
endfunction

// next state of every entry after one rising edge
function automatic void updateModel(
	input logic rstIn,
	input logic weIn,
	input logic clrIn,
	input regAddrT wAddr,
	input dataT wData,
	input adcSampleT adcIn,
	input logic restIn,
	input logic activeIn,
	input logic readyIn
);
	for (int i = 0; i < REG_COUNT; i++) begin
		if (!rstIn) begin
			model[i] = '0;
		end else if (i == int'(REG_ADC)) begin
			model[i] = dataT'(adcIn);
		end else if (i == int'(REG_REST)) begin
			model[i] = dataT'(restIn);
		end else if (i == int'(REG_ACTIVE)) begin
			model[i] = dataT'(activeIn);
		end else if (i == int'(REG_ADC_READY)) begin
			model[i] = dataT'(readyIn);
		end else if (isSampledEntry(i)) begin
			model[i] = '0;
		end else if (clrIn) begin
			model[i] = '0;
		end else if (weIn && (int'(wAddr) == i)) begin
			model[i] = wData;
		end
	end
endfunction

// display shows bits 20 down to 5 of entry 3
function automatic dataT expectedDisplay();
	return dataT'(model[REG_DISPLAY][20:5]);
endfunction

task automatic checkValue(input string name, input dataT actual, input dataT expected);
	if (actual !== expected) begin
		errorCount++;
		$display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
			$time, name, actual, expected);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first mismatch");
	end
endtask

// ==== tests/servoRegSystemTb.sv ====
// runs with short servo and tick timing; stops at the first mismatch or after 20000 cycles
`timescale 1ns/1ps

module servoRegSystemTb;

	import servoRegPkg::*;

	localparam int unsigned PERIOD_CYCLES = 200;
	localparam int unsigned PULSE_BASE = 20;
	localparam int unsigned PULSE_STEP = 10;
	localparam int unsigned TICK_DIVIDE = 23;
	localparam int unsigned RANDOM_SEED = 32'hb7c5_5b31;
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int RANDOM_CYCLES = 2000;
	localparam int TICK_PULSES = 5;

	logic clock;
	logic rstN;
	logic writeEnable;
	logic clearRegs;
	regAddrT writeAddr;
	regAddrT readAddrA;
	regAddrT readAddrB;
	dataT writeData;
	adcSampleT adcSample;
	logic rest;
	logic active;
	dataT readDataA;
	dataT readDataB;
	logic servoOut;
	displayT displayWord;

	int cycleCount;
	// falling edges left with rstN low
	int resetLeft = 3;

	`include "tbModel.svh"

	servoRegSystem #(
		.PERIOD_CYCLES(PERIOD_CYCLES),
		.PULSE_BASE(PULSE_BASE),
		.PULSE_STEP(PULSE_STEP),
		.TICK_DIVIDE(TICK_DIVIDE)
	) servoRegSystem_inst (
		.clock(clock),
		.rstN(rstN),
		.writeEnable(writeEnable),
		.clearRegs(clearRegs),
		.writeAddr(writeAddr),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeData(writeData),
		.adcSample(adcSample),
		.rest(rest),
		.active(active),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.servoOut(servoOut),
		.displayWord(displayWord)
	);

	// first rising edge at 5 ns, already under reset
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: the test sequence was still running after %0d cycles", cycleCount);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	// one cycle: drive at the falling edge, check the settled outputs, advance the model
	task automatic runCycle(
		input logic weIn,
		input logic clrIn,
		input regAddrT wAddr,
		input dataT wData,
		input regAddrT rAddrA
	);
		logic wasInReset;
		logic readyNow;
		@(negedge clock);
		wasInReset = !rstN;
		rstN = (resetLeft == 0);
		if (resetLeft > 0) begin
			resetLeft--;
		end
		writeEnable = weIn;
		clearRegs = clrIn;
		writeAddr = wAddr;
		writeData = wData;
		readAddrA = rAddrA;
		// bias port B toward the write index for read-during-write
		if (($urandom % 4) == 0) begin
			readAddrB = wAddr;
		end else begin
			readAddrB = regAddrT'($urandom % 32);
		end
		adcSample = adcSampleT'($urandom);
		rest = ($urandom % 2) == 1;
		active = ($urandom % 2) == 1;
		#1;
		checkValue("readDataA", readDataA, model[readAddrA]);
		checkValue("readDataB", readDataB, model[readAddrB]);
		checkValue("displayWord", dataT'(displayWord), expectedDisplay());
		if (wasInReset) begin
			checkValue("servoOut after reset", dataT'(servoOut), '0);
		end
		readyNow = servoRegSystem_inst.adcReady;
		updateModel(rstN, weIn, clrIn, wAddr, wData, adcSample, rest, active, readyNow);
	endtask

	task automatic idleCycle();
		runCycle(1'b0, 1'b0, regAddrT'($urandom % 32), dataT'($urandom),
			regAddrT'($urandom % 32));
	endtask

	task automatic runRandomTraffic();
		logic weIn;
		logic clrIn;
		regAddrT wAddr;
		regAddrT rAddr;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			weIn = ($urandom % 2) == 0;
			clrIn = ($urandom % 50) == 0;
			wAddr = regAddrT'($urandom % 32);
			if (($urandom % 4) == 0) begin
				rAddr = wAddr;
			end else begin
				rAddr = regAddrT'($urandom % 32);
			end
			runCycle(weIn, clrIn, wAddr, dataT'($urandom), rAddr);
		end
	endtask

	task automatic checkReadOnlyWrites();
		regAddrT readOnly [0:4];
		readOnly = '{REG_ZERO, REG_ADC, REG_REST, REG_ACTIVE, REG_ADC_READY};
		for (int i = 0; i < 5; i++) begin
			runCycle(1'b1, 1'b0, readOnly[i], 32'hffff_ffff, readOnly[i]);
			runCycle(1'b0, 1'b0, REG_ZERO, '0, readOnly[i]);
			checkValue("readDataA upper bits", readDataA >> ADC_W, '0);
		end
	endtask

	// distance between highs of entry 8
	task automatic checkTick();
		int highs;
		int lastHigh;
		int n;
		highs = 0;
		lastHigh = -1;
		n = 0;
		while (highs < TICK_PULSES) begin
			runCycle(1'b0, 1'b0, REG_ZERO, '0, REG_ADC_READY);
			if (readDataA[0]) begin
				if (lastHigh >= 0) begin
					checkValue("entry 8 pulse spacing", dataT'(n - lastHigh), dataT'(TICK_DIVIDE));
				end
				lastHigh = n;
				highs++;
			end
			n++;
		end
	endtask

	task automatic measureServo(input servoCaseT caseIn);
		dataT wData;
		int expectedHigh;
		int highCount;
		int lowCount;
		expectedHigh = int'(PULSE_BASE) + int'(caseIn) * int'(PULSE_STEP);
		wData = dataT'($urandom);
		wData[2:0] = caseIn;
		runCycle(1'b1, 1'b0, REG_SERVO, wData, REG_SERVO);
		// new case only applies from the next frame
		repeat (PERIOD_CYCLES) idleCycle();
		while (servoOut) idleCycle();
		while (!servoOut) idleCycle();
		highCount = 0;
		while (servoOut) begin
			highCount++;
			idleCycle();
		end
		lowCount = 0;
		while (!servoOut) begin
			lowCount++;
			idleCycle();
		end
		checkValue("servoOut high time", dataT'(highCount), dataT'(expectedHigh));
		checkValue("servoOut period", dataT'(highCount + lowCount), dataT'(PERIOD_CYCLES));
	endtask

	initial begin
		int seedValue;
		seedValue = $urandom(RANDOM_SEED);
		rstN = 1'b0;
		writeEnable = 1'b0;
		clearRegs = 1'b0;
		writeAddr = '0;
		readAddrA = '0;
		readAddrB = '0;
		writeData = '0;
		adcSample = '0;
		rest = 1'b0;
		active = 1'b0;
		for (int i = 0; i < REG_COUNT; i++) begin
			model[i] = '0;
		end
		// reset cycles, then the cycle that releases rstN
		repeat (4) idleCycle();
		runRandomTraffic();
		checkReadOnlyWrites();
		checkTick();
		for (int c = 0; c < 8; c++) begin
			measureServo(servoCaseT'(c));
		end
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== servoRegSystem.f ====
+incdir+tests
verilog/servoRegPkg.sv
verilog/ioRegFile.sv
verilog/servoPwm.sv
verilog/sampleTick.sv
verilog/servoRegSystem.sv
tests/servoRegSystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the servo register file testbench with Verilator.
# Exit status is nonzero when the log holds the fail message or no pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

{ verilator --binary --timing --assert -Wno-fatal \
	--top-module servoRegSystemTb -f servoRegSystem.f \
	&& ./obj_dir/VservoRegSystemTb; } > "$LOG" 2>&1 \
	|| echo "build or simulation ended with an error status" >> "$LOG"

cat "$LOG"

grep -q "SIMULATION FAILED" "$LOG" && exit 1
grep -q "SIMULATION PASSED" "$LOG" || exit 1
exit 0
